//--- list.f
+incdir+source
source/spi_slave_pkg.sv
source/spi_char_if.sv
source/spi_pin_sync.sv
source/spi_char_shifter.sv
source/spi_word_packer.sv
source/spi_slave_top.sv
testbench/tb_spi_slave.sv

//--- run.sh
#!/bin/sh
# build the SPI slave testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_spi_slave -f list.f -o tb_spi_slave &&
./obj_dir/tb_spi_slave | tee /dev/stderr | grep -q "All checks passed" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- source/spi_char_if.sv
`timescale 1ns/100ps
`default_nettype none

interface spi_char_if;

    spi_slave_pkg::char_t rx_char;   // completed receive character
    logic                 rx_stb;    // rx_char valid, one cycle
    spi_slave_pkg::char_t tx_char;   // next transmit character
    logic                 tx_take;   // tx_char consumed
    logic                 frame_end; // slave deselected

    // bit engine side
    modport engine (
        output rx_char,
        output rx_stb,
        input  tx_char,
        output tx_take,
        output frame_end
    );

    // word buffer side
    modport host (
        input  rx_char,
        input  rx_stb,
        output tx_char,
        input  tx_take,
        input  frame_end
    );

endinterface

`default_nettype wire

//--- source/spi_char_shifter.sv
`timescale 1ns/100ps
`default_nettype none

module spi_char_shifter (
    input  wire                      S_SYSCLK,
    input  wire                      S_RESETN,
    input  wire                      active,
    input  wire                      sample_stb,
    input  wire                      shift_stb,
    input  wire                      mosi_s,
    input  wire                      lsb_first,
    input  wire                      cpha,
    input  wire spi_slave_pkg::bit_idx_t char_len,
    output logic                     spi_miso,
    output logic                     spi_miso_oe,
    spi_char_if.engine               chr
);

    spi_slave_pkg::shift_state_t state;
    spi_slave_pkg::bit_idx_t     bit_cnt;
    spi_slave_pkg::bit_idx_t     first_bit;
    spi_slave_pkg::bit_idx_t     last_bit;
    spi_slave_pkg::bit_idx_t     next_bit;
    spi_slave_pkg::char_t        tx_sr;
    spi_slave_pkg::char_t        rx_sr;
    logic                        hold;        // next shift strobe drives, no advance
    logic                        first_char;
    logic                        miso_q;
    logic                        rx_stb_q;
    logic                        frame_end_q;

    assign first_bit = lsb_first ? '0 : char_len;
    assign last_bit  = lsb_first ? char_len : '0;
    assign next_bit  = lsb_first ? bit_cnt + 1'b1 : bit_cnt - 1'b1;

    assign spi_miso      = miso_q;
    assign spi_miso_oe   = active;
    assign chr.tx_take   = active && (state == spi_slave_pkg::ST_LOAD);
    assign chr.rx_char   = rx_sr;
    assign chr.rx_stb    = rx_stb_q;
    assign chr.frame_end = frame_end_q;

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            state       <= spi_slave_pkg::ST_IDLE;
            bit_cnt     <= '0;
            hold        <= 1'b0;
            first_char  <= 1'b1;
            miso_q      <= 1'b1;
            rx_stb_q    <= 1'b0;
            frame_end_q <= 1'b0;
        end else begin
            rx_stb_q    <= 1'b0;
            frame_end_q <= 1'b0;
            if (!active) begin
                frame_end_q <= (state != spi_slave_pkg::ST_IDLE);
                state       <= spi_slave_pkg::ST_IDLE;
                hold        <= 1'b0;
            end else begin
                case (state)
                    spi_slave_pkg::ST_IDLE: begin
                        first_char <= 1'b1;
                        state      <= spi_slave_pkg::ST_LOAD;
                    end
                    spi_slave_pkg::ST_LOAD: begin
                        bit_cnt    <= first_bit;
                        // mode 0/2 drives the very first bit right away
                        hold       <= cpha | ~first_char;
                        first_char <= 1'b0;
                        if (!cpha && first_char) begin
                            miso_q <= chr.tx_char[first_bit];
                        end
                        state      <= spi_slave_pkg::ST_SHIFT;
                    end
                    spi_slave_pkg::ST_SHIFT: begin
                        if (shift_stb) begin
                            if (hold) begin
                                hold   <= 1'b0;
                                miso_q <= tx_sr[bit_cnt];
                            end else begin
                                bit_cnt <= next_bit;
                                miso_q  <= tx_sr[next_bit];
                            end
                        end
                        if (sample_stb && (bit_cnt == last_bit)) begin
                            rx_stb_q <= 1'b1;  // rx_sr complete next cycle
                            state    <= spi_slave_pkg::ST_LOAD;
                        end
                    end
                    default: begin
                        state <= spi_slave_pkg::ST_IDLE;
                    end
                endcase
            end
        end
    end

    // character data
    always_ff @(posedge S_SYSCLK) begin
        if (chr.tx_take) begin
            tx_sr <= chr.tx_char;
            rx_sr <= '0;  // unused high bits read as zero
        end else if (sample_stb && (state == spi_slave_pkg::ST_SHIFT)) begin
            rx_sr[bit_cnt] <= mosi_s;
        end
    end

endmodule

`default_nettype wire

//--- source/spi_pin_sync.sv
`include "spi_slave_defines.svh"
`timescale 1ns/100ps
`default_nettype none

module spi_pin_sync (
    input  wire  S_SYSCLK,
    input  wire  S_RESETN,
    input  wire  enable,
    input  wire  cpol,
    input  wire  cpha,
    input  wire  cspol,
    input  wire  spi_cs,
    input  wire  spi_sck,
    input  wire  spi_mosi,
    output logic active,
    output logic sample_stb,
    output logic shift_stb,
    output logic mosi_s
);

    localparam int STAGES = `SPI_SYNC_STAGES;

    logic [STAGES-1:0] sck_sync;
    logic [STAGES-1:0] cs_sync;
    logic [STAGES-1:0] mosi_sync;
    logic              sck_d;
    logic              sel;
    logic              sck_rise;
    logic              sck_fall;
    logic              first_edge;
    logic              second_edge;

    assign sel         = enable & (cspol ? ~cs_sync[STAGES-1] : cs_sync[STAGES-1]);
    assign sck_rise    = sck_sync[STAGES-1] & ~sck_d;
    assign sck_fall    = ~sck_sync[STAGES-1] & sck_d;
    assign first_edge  = cpol ? sck_fall : sck_rise;  // leading edge of the pulse
    assign second_edge = cpol ? sck_rise : sck_fall;
    assign mosi_s      = mosi_sync[STAGES-1];

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            sck_sync   <= {STAGES{cpol}};   // idle clock level
            cs_sync    <= {STAGES{cspol}};  // deselected level
            mosi_sync  <= '0;
            sck_d      <= cpol;
            active     <= 1'b0;
            sample_stb <= 1'b0;
            shift_stb  <= 1'b0;
        end else begin
            sck_sync   <= {sck_sync[STAGES-2:0], spi_sck};
            cs_sync    <= {cs_sync[STAGES-2:0], spi_cs};
            mosi_sync  <= {mosi_sync[STAGES-2:0], spi_mosi};
            sck_d      <= sck_sync[STAGES-1];
            active     <= sel;
            sample_stb <= sel & (cpha ? second_edge : first_edge);
            shift_stb  <= sel & (cpha ? first_edge : second_edge);
        end
    end

endmodule

`default_nettype wire

//--- source/spi_slave_defines.svh
`ifndef SPI_SLAVE_DEFINES_SVH
`define SPI_SLAVE_DEFINES_SVH

`default_nettype none

// host side word
`define SPI_WORD_W 32

// widest character, 16 bit slot
`define SPI_CHAR_W 16

// enough to index any bit of a character
`define SPI_BIT_IDX_W 4

// flops per pin before edge detection
`define SPI_SYNC_STAGES 2

`default_nettype wire

`endif

//--- source/spi_slave_pkg.sv
`include "spi_slave_defines.svh"
`default_nettype none

package spi_slave_pkg;

    // one host word, four byte slots or two halfword slots
    typedef logic [`SPI_WORD_W-1:0] word_t;

    // right aligned, unused upper bits zero
    typedef logic [`SPI_CHAR_W-1:0] char_t;

    // index of the last bit is used as the length code
    typedef logic [`SPI_BIT_IDX_W-1:0] bit_idx_t;

    typedef logic [1:0] slot_idx_t;

    typedef enum logic [1:0] {
        ST_IDLE,  // deselected
        ST_LOAD,  // fetch next tx character
        ST_SHIFT  // bits moving
    } shift_state_t;

endpackage

`default_nettype wire

//--- source/spi_slave_top.sv
`timescale 1ns/100ps
`default_nettype none

module spi_slave_top (
    input  wire                      S_SYSCLK,
    input  wire                      S_RESETN,
    input  wire                      enable,
    input  wire                      cpol,
    input  wire                      cpha,
    input  wire                      cspol,      // high for active low select
    input  wire                      lsb_first,
    input  wire spi_slave_pkg::bit_idx_t char_len,   // index of last bit
    input  wire                      spi_cs,
    input  wire                      spi_sck,
    input  wire                      spi_mosi,
    output logic                     spi_miso,
    output logic                     spi_miso_oe,
    input  wire spi_slave_pkg::word_t    tx_word,
    input  wire                      tx_valid,
    output logic                     tx_ready,
    output spi_slave_pkg::word_t     rx_word,
    output logic                     rx_valid,
    input  wire                      rx_ready,
    output logic                     rx_overrun
);

    logic active;
    logic sample_stb;
    logic shift_stb;
    logic mosi_s;

    spi_char_if u_chr ();

    spi_pin_sync u_pin_sync (
        .S_SYSCLK   (S_SYSCLK),
        .S_RESETN   (S_RESETN),
        .enable     (enable),
        .cpol       (cpol),
        .cpha       (cpha),
        .cspol      (cspol),
        .spi_cs     (spi_cs),
        .spi_sck    (spi_sck),
        .spi_mosi   (spi_mosi),
        .active     (active),
        .sample_stb (sample_stb),
        .shift_stb  (shift_stb),
        .mosi_s     (mosi_s)
    );

    spi_char_shifter u_shifter (
        .S_SYSCLK    (S_SYSCLK),
        .S_RESETN    (S_RESETN),
        .active      (active),
        .sample_stb  (sample_stb),
        .shift_stb   (shift_stb),
        .mosi_s      (mosi_s),
        .lsb_first   (lsb_first),
        .cpha        (cpha),
        .char_len    (char_len),
        .spi_miso    (spi_miso),
        .spi_miso_oe (spi_miso_oe),
        .chr         (u_chr.engine)
    );

    spi_word_packer u_packer (
        .S_SYSCLK   (S_SYSCLK),
        .S_RESETN   (S_RESETN),
        .char_len   (char_len),
        .tx_word    (tx_word),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .rx_word    (rx_word),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .rx_overrun (rx_overrun),
        .chr        (u_chr.host)
    );

endmodule

`default_nettype wire

//--- source/spi_word_packer.sv
`timescale 1ns/100ps
`default_nettype none

module spi_word_packer (
    input  wire                      S_SYSCLK,
    input  wire                      S_RESETN,
    input  wire spi_slave_pkg::bit_idx_t char_len,
    input  wire spi_slave_pkg::word_t    tx_word,
    input  wire                      tx_valid,
    output logic                     tx_ready,
    output spi_slave_pkg::word_t     rx_word,
    output logic                     rx_valid,
    input  wire                      rx_ready,
    output logic                     rx_overrun,
    spi_char_if.host                 chr
);

    spi_slave_pkg::word_t     tx_buf;
    spi_slave_pkg::word_t     rx_acc;
    spi_slave_pkg::word_t     rx_fill;
    spi_slave_pkg::slot_idx_t tx_slot;
    spi_slave_pkg::slot_idx_t rx_slot;
    spi_slave_pkg::slot_idx_t last_slot;
    spi_slave_pkg::char_t     tx_slot_data;
    spi_slave_pkg::char_t     char_mask;
    logic                     wide;       // 16 bit slots
    logic                     tx_full;
    logic                     rx_blocked;

    assign wide       = (char_len > 7);
    assign last_slot  = wide ? 2'd1 : 2'd3;
    assign rx_blocked = rx_valid & ~rx_ready;  // previous word still pending

    always_comb begin
        for (int i = 0; i < $bits(spi_slave_pkg::char_t); i++) begin
            char_mask[i] = (i <= char_len);
        end
    end

    always_comb begin
        if (wide) begin
            tx_slot_data = tx_buf[{tx_slot[0], 4'b0000} +: 16];
        end else begin
            tx_slot_data = {8'h00, tx_buf[{tx_slot, 3'b000} +: 8]};
        end
    end

    assign chr.tx_char = tx_full ? (tx_slot_data & char_mask) : '1;  // idle ones

    // first slot starts a fresh word
    always_comb begin
        rx_fill = (rx_slot == 2'd0) ? '0 : rx_acc;
        if (wide) begin
            rx_fill[{rx_slot[0], 4'b0000} +: 16] = chr.rx_char;
        end else begin
            rx_fill[{rx_slot, 3'b000} +: 8] = chr.rx_char[7:0];
        end
    end

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            tx_full    <= 1'b0;
            tx_ready   <= 1'b0;
            tx_slot    <= '0;
            rx_slot    <= '0;
            rx_valid   <= 1'b0;
            rx_overrun <= 1'b0;
        end else begin
            rx_overrun <= 1'b0;
            if (tx_valid && tx_ready) begin
                tx_full  <= 1'b1;
                tx_ready <= 1'b0;
            end else begin
                tx_ready <= ~tx_full;
            end
            if (rx_valid && rx_ready) begin
                rx_valid <= 1'b0;
            end
            if (chr.frame_end) begin
                tx_slot <= '0;
                rx_slot <= '0;
                if (tx_slot != 2'd0) begin
                    tx_full <= 1'b0;  // drop rest of a started word
                end
            end else begin
                if (chr.tx_take && tx_full) begin
                    if (tx_slot == last_slot) begin
                        tx_slot <= '0;
                        tx_full <= 1'b0;
                    end else begin
                        tx_slot <= tx_slot + 1'b1;
                    end
                end
                if (chr.rx_stb) begin
                    if (rx_slot == last_slot) begin
                        rx_slot <= '0;
                        if (rx_blocked) begin
                            rx_overrun <= 1'b1;
                        end else begin
                            rx_valid <= 1'b1;
                        end
                    end else begin
                        rx_slot <= rx_slot + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (tx_valid && tx_ready) begin
            tx_buf <= tx_word;
        end
        if (chr.rx_stb) begin
            rx_acc <= rx_fill;
            if ((rx_slot == last_slot) && !rx_blocked) begin
                rx_word <= rx_fill;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_spi_slave.sv
`timescale 1ns/100ps
`default_nettype none

module tb_spi_slave;

    localparam int HALF       = 6;    // sck half period in clock cycles
    localparam int TOTAL_BITS = 312;  // bits over all frames of the run
    localparam int FRAMES     = 11;
    localparam int TIMEOUT    = TOTAL_BITS * 2 * HALF + FRAMES * 60 + 200;

    logic                    S_SYSCLK;
    logic                    S_RESETN;
    logic                    enable;
    logic                    cpol;
    logic                    cpha;
    logic                    cspol;
    logic                    lsb_first;
    spi_slave_pkg::bit_idx_t char_len;
    logic                    spi_cs;
    logic                    spi_sck;
    logic                    spi_mosi;
    logic                    spi_miso;
    logic                    spi_miso_oe;
    spi_slave_pkg::word_t    tx_word;
    logic                    tx_valid;
    logic                    tx_ready;
    spi_slave_pkg::word_t    rx_word;
    logic                    rx_valid;
    logic                    rx_ready;
    logic                    rx_overrun;

    logic [31:0] lfsr;
    logic [15:0] mosi_sent[$];  // characters sent by the master model
    logic [15:0] miso_got[$];
    int          cycle_cnt;
    int          overrun_cnt;

    spi_slave_top u_dut (.*);

    initial begin
        S_SYSCLK = 1'b0;
        forever #50 S_SYSCLK = ~S_SYSCLK;
    end

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge S_SYSCLK);
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r[i] = lfsr[0];
        end
        return r;
    endfunction

    // chars sit in the low bits of consecutive slots, slot 0 lowest
    function automatic spi_slave_pkg::word_t pack_sent(input int slot_w);
        spi_slave_pkg::word_t w;
        w = '0;
        for (int i = 0; i < mosi_sent.size(); i++) begin
            w = w | (spi_slave_pkg::word_t'(mosi_sent[i]) << (i * slot_w));
        end
        return w;
    endfunction

    task automatic set_mode(input logic pol, input logic pha, input logic lsb, input int len);
        @(negedge S_SYSCLK);
        cpol      = pol;
        cpha      = pha;
        lsb_first = lsb;
        char_len  = 4'(len - 1);
        spi_sck   = pol;  // idle level
        wait_cycles(HALF);
    endtask

    task automatic offer_tx(input spi_slave_pkg::word_t w);
        tx_word  = w;
        tx_valid = 1'b1;
        while (!tx_ready) @(negedge S_SYSCLK);
        @(negedge S_SYSCLK);
        tx_valid = 1'b0;
    endtask

    task automatic run_frame(input int nchars);
        int          nbits;
        int          idx;
        logic [15:0] out_c;
        logic [15:0] in_c;
        nbits = int'(char_len) + 1;
        mosi_sent.delete();
        miso_got.delete();
        spi_cs = ~cspol;
        wait_cycles(8);
        assert (spi_miso_oe) else begin
            $display("spi_miso_oe stayed low while the slave was selected");
            stop_run();
        end
        for (int c = 0; c < nchars; c++) begin
            out_c = 16'(rand_bits(nbits));
            in_c  = '0;
            for (int b = 0; b < nbits; b++) begin
                idx = lsb_first ? b : nbits - 1 - b;
                if (!cpha) begin
                    spi_mosi = out_c[idx];
                    wait_cycles(HALF);
                    in_c[idx] = spi_miso;
                    spi_sck   = ~cpol;  // sampling edge
                    wait_cycles(HALF);
                    spi_sck   = cpol;
                end else begin
                    spi_sck  = ~cpol;   // shifting edge
                    spi_mosi = out_c[idx];
                    wait_cycles(HALF);
                    in_c[idx] = spi_miso;
                    spi_sck   = cpol;
                    wait_cycles(HALF);
                end
            end
            mosi_sent.push_back(out_c);
            miso_got.push_back(in_c);
        end
        wait_cycles(HALF);
        spi_cs = cspol;
        wait_cycles(8);
        assert (!spi_miso_oe) else begin
            $display("spi_miso_oe stayed high after the slave was deselected");
            stop_run();
        end
    endtask

    task automatic check_miso(input spi_slave_pkg::word_t w, input logic with_tx);
        int          nbits;
        int          slot_w;
        logic [31:0] exp_c;
        nbits  = int'(char_len) + 1;
        slot_w = (nbits > 8) ? 16 : 8;
        for (int i = 0; i < miso_got.size(); i++) begin
            exp_c = with_tx ? (w >> (i * slot_w)) : '1;
            exp_c = exp_c & ((32'd1 << nbits) - 32'd1);
            assert (miso_got[i] == exp_c[15:0]) else begin
                $display("MISMATCH spi_miso char %0d: got %h expected %h",
                         i, miso_got[i], exp_c[15:0]);
                stop_run();
            end
        end
    endtask

    task automatic wait_rx(input spi_slave_pkg::word_t exp);
        while (!rx_valid) @(negedge S_SYSCLK);
        assert (rx_word == exp) else begin
            $display("MISMATCH rx_word: got %h expected %h", rx_word, exp);
            stop_run();
        end
    endtask

    task automatic take_rx();
        rx_ready = 1'b1;
        @(negedge S_SYSCLK);
        rx_ready = 1'b0;
    endtask

    task automatic exchange_word();
        int                   slot_w;
        spi_slave_pkg::word_t w;
        slot_w = (char_len > 4'd7) ? 16 : 8;
        w      = rand_bits(32);
        offer_tx(w);
        run_frame(32 / slot_w);
        check_miso(w, 1'b1);
        wait_rx(pack_sent(slot_w));
        take_rx();
    endtask

    always @(negedge S_SYSCLK) begin
        if (rx_overrun === 1'b1) begin
            overrun_cnt <= overrun_cnt + 1;
        end
    end

    always @(posedge S_SYSCLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT);
            stop_run();
        end
    end

    assert property (@(posedge S_SYSCLK) disable iff (!S_RESETN)
        rx_valid && !rx_ready |=> rx_valid)
    else begin
        $display("rx_valid dropped without a transfer");
        stop_run();
    end

    assert property (@(posedge S_SYSCLK) disable iff (!S_RESETN)
        rx_valid && !rx_ready |=> $stable(rx_word))
    else begin
        $display("rx_word changed to %h while the word was held", rx_word);
        stop_run();
    end

    assert property (@(posedge S_SYSCLK) disable iff (!S_RESETN)
        rx_overrun |-> rx_valid)
    else begin
        $display("rx_overrun pulsed with no word pending");
        stop_run();
    end

    initial begin
        spi_slave_pkg::word_t held;
        spi_slave_pkg::word_t w;
        int                   mode;
        S_RESETN    = 1'b0;
        enable      = 1'b0;
        cpol        = 1'b0;
        cpha        = 1'b0;
        cspol       = 1'b1;
        lsb_first   = 1'b0;
        char_len    = 4'd7;
        spi_cs      = 1'b1;
        spi_sck     = 1'b0;
        spi_mosi    = 1'b0;
        tx_word     = '0;
        tx_valid    = 1'b0;
        rx_ready    = 1'b0;
        lfsr        = 32'h3f5163d1;
        cycle_cnt   = 0;
        overrun_cnt = 0;
        wait_cycles(8);
        assert (!tx_ready && !rx_valid && !rx_overrun && !spi_miso_oe) else begin
            $display("outputs not idle during reset");
            stop_run();
        end
        S_RESETN = 1'b1;
        enable   = 1'b1;
        wait_cycles(4);

        for (mode = 0; mode < 4; mode++) begin  // mode 0 first
            set_mode(mode[1], mode[0], 1'b0, 8);
            exchange_word();
        end
        set_mode(1'b0, 1'b0, 1'b1, 16);
        exchange_word();
        set_mode(1'b0, 1'b0, 1'b1, 12);
        exchange_word();
        set_mode(1'b0, 1'b0, 1'b0, 4);
        exchange_word();

        // empty tx buffer, then a second word while the first is held
        set_mode(1'b0, 1'b0, 1'b0, 8);
        run_frame(4);
        check_miso('0, 1'b0);
        held = pack_sent(8);
        wait_rx(held);
        run_frame(4);
        check_miso('0, 1'b0);
        assert (overrun_cnt == 1) else begin
            $display("MISMATCH rx_overrun pulses: got %h expected %h", overrun_cnt, 1);
            stop_run();
        end
        wait_rx(held);
        take_rx();

        enable = 1'b0;  // no false select while the polarity flips
        cspol  = 1'b0;
        spi_cs = 1'b0;
        wait_cycles(4);
        enable = 1'b1;
        wait_cycles(2);
        w = rand_bits(32);
        offer_tx(w);
        run_frame(2);
        check_miso(w, 1'b1);
        wait_cycles(2 * HALF);
        assert (!rx_valid) else begin
            $display("rx_valid rose after a partial word");
            stop_run();
        end
        exchange_word();
        assert (overrun_cnt == 1) else begin
            $display("MISMATCH rx_overrun pulses: got %h expected %h", overrun_cnt, 1);
            stop_run();
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
